//--- tag_store_consts.svh
`ifndef TAG_STORE_CONSTS_SVH
`define TAG_STORE_CONSTS_SVH

// Geometry of the tag store
// Number of ways per set
`define TAG_WAYS 4

// Set index width, 64 sets
`define TAG_INDEX_W 6

// Stored address tag width
`define TAG_W 10

// Timing of the tag memories
// Cycles from a RAM read request to its data
`define TAG_RAM_LATENCY 1

`endif

//--- tag_geom_pkg.sv
`include "tag_store_consts.svh"

package tag_geom_pkg;

  // One bit per way, used for enables, hits and victims
  typedef logic [`TAG_WAYS-1:0] way_vec_t;

  // Set index, doubles as the RAM address
  typedef logic [`TAG_INDEX_W-1:0] index_t;

  // Address tag as stored in the memories
  typedef logic [`TAG_W-1:0] tag_t;

  // One stored entry
  typedef struct packed {
    // Entry holds a line
    logic valid;
    // Line differs from the backing memory
    logic dirty;
    tag_t tag;
  } tag_entry_t;

endpackage

//--- tag_req_pkg.sv
package tag_req_pkg;

  // Request modes of the tag store
  typedef enum logic {
    LOOKUP = 1'b0,
    FLUSH  = 1'b1
  } store_mode_e;

  // Request as accepted from the requester
  typedef struct packed {
    store_mode_e            mode;
    // Ways to look in, or the single way to flush
    tag_geom_pkg::way_vec_t way;
    tag_geom_pkg::index_t   index;
    tag_geom_pkg::tag_t     tag;
    // Lookup comes from a write
    logic                   dirty;
  } store_req_t;

  // Response handed to the spill register
  typedef struct packed {
    // Hit way, victim way or flushed way
    tag_geom_pkg::way_vec_t way;
    logic                   hit;
    // Entry must be written back
    logic                   evict;
    // Tag of the entry to write back
    tag_geom_pkg::tag_t     evict_tag;
  } store_res_t;

endpackage

//--- tag_ram_if.sv
`timescale 1ns/1ps
`include "tag_store_consts.svh"

interface tag_ram_if;

  // Request side, one enable per way
  tag_geom_pkg::way_vec_t   ram_req;
  tag_geom_pkg::way_vec_t   ram_we;
  tag_geom_pkg::index_t     ram_index;
  tag_geom_pkg::tag_entry_t ram_wdata;

  // Read side, one entry and one token per way
  tag_geom_pkg::tag_entry_t [`TAG_WAYS-1:0] ram_rdata;
  tag_geom_pkg::way_vec_t                   ram_rvalid;

  // Controller view
  modport ctrl (
    output ram_req, ram_we, ram_index, ram_wdata,
    input  ram_rdata, ram_rvalid
  );

  // Memory bank view
  modport bank (
    input  ram_req, ram_we, ram_index, ram_wdata,
    output ram_rdata, ram_rvalid
  );

endinterface

//--- tag_ram_bank.sv
`timescale 1ns/1ps
`include "tag_store_consts.svh"

module tag_ram_bank (
  input  logic clk_i,
  input  logic rst_i,
  tag_ram_if.bank ram
);

  localparam int LAT = `TAG_RAM_LATENCY;

  for (genvar w = 0; w < `TAG_WAYS; w++) begin : gen_way
    // Entry array of this way
    tag_geom_pkg::tag_entry_t mem [2**`TAG_INDEX_W];
    // Read data pipeline, last stage is the output
    tag_geom_pkg::tag_entry_t rd_pipe [LAT];
    // Read-valid tokens, one per stage
    logic [LAT-1:0]           vld_pipe;
    logic                     rd_en;

    // A request without write enable is a read
    assign rd_en = ram.ram_req[w] & ~ram.ram_we[w];

    always_ff @(posedge clk_i) begin
      if (ram.ram_req[w] && ram.ram_we[w]) begin
        mem[ram.ram_index] <= ram.ram_wdata;
      end
      if (rd_en) begin
        rd_pipe[0] <= mem[ram.ram_index];
      end
      // Later stages only move with their token, so data stays after arrival
      for (int s = 1; s < LAT; s++) begin
        if (vld_pipe[s-1]) begin
          rd_pipe[s] <= rd_pipe[s-1];
        end
      end
    end

    // Token shift register
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        vld_pipe <= '0;
      end else begin
        vld_pipe <= (vld_pipe << 1) | LAT'(rd_en);
      end
    end

    assign ram.ram_rdata[w]  = rd_pipe[LAT-1];
    assign ram.ram_rvalid[w] = vld_pipe[LAT-1];
  end

endmodule

//--- evict_box.sv
`timescale 1ns/1ps
`include "tag_store_consts.svh"

module evict_box (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  tag_geom_pkg::way_vec_t tag_valid_i,
  input  tag_geom_pkg::way_vec_t tag_dirty_i,
  input  tag_geom_pkg::way_vec_t spm_lock_i,
  output tag_geom_pkg::way_vec_t way_o,
  output logic                   evict_o,
  output logic                   valid_o
);

  localparam int PTR_W = $clog2(`TAG_WAYS);

  tag_geom_pkg::way_vec_t unlocked, free_ways, pick_way;
  logic [PTR_W-1:0]       ptr_q, pick_idx;
  logic                   pick_ptr, decide;
  logic                   valid_q, evict_q;
  tag_geom_pkg::way_vec_t way_q;

  // Scratchpad ways never take part
  assign unlocked  = ~spm_lock_i;
  assign free_ways = unlocked & ~tag_valid_i;
  // Decide once, on the cycle the request rises
  assign decide    = req_i & ~valid_q;

  always_comb begin : proc_pick
    logic [PTR_W-1:0] cand;
    pick_way = '0;
    pick_ptr = 1'b0;
    pick_idx = ptr_q;
    cand     = ptr_q;
    if (|free_ways) begin
      // Lowest free way wins, walk down so the last match is the lowest
      for (int i = `TAG_WAYS - 1; i >= 0; i--) begin
        if (free_ways[i]) begin
          pick_way = tag_geom_pkg::way_vec_t'(1) << i;
        end
      end
    end else begin
      // Round robin, first unlocked way at or after the pointer
      pick_ptr = 1'b1;
      for (int i = `TAG_WAYS - 1; i >= 0; i--) begin
        cand = PTR_W'(ptr_q + i);
        if (unlocked[cand]) begin
          pick_way = tag_geom_pkg::way_vec_t'(1) << cand;
          pick_idx = cand;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      way_q   <= '0;
      evict_q <= 1'b0;
      ptr_q   <= '0;
    end else begin
      valid_q <= req_i;
      if (decide) begin
        way_q   <= pick_way;
        // Victim holds a valid dirty line
        evict_q <= |(pick_way & tag_valid_i & tag_dirty_i);
        if (pick_ptr) begin
          ptr_q <= pick_idx + 1'b1;
        end
      end
    end
  end

  assign way_o   = way_q;
  assign evict_o = evict_q;
  assign valid_o = valid_q;

endmodule

//--- spill_reg.sv
`timescale 1ns/1ps

module spill_reg (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   valid_i,
  input  tag_req_pkg::store_res_t data_i,
  output logic                   ready_o,
  output logic                   valid_o,
  output tag_req_pkg::store_res_t data_o,
  input  logic                   ready_i
);

  // Slot A takes new data, slot B holds the older one on a stall
  tag_req_pkg::store_res_t a_data_q, b_data_q;
  logic                    a_full_q, b_full_q;
  logic                    a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i & ready_o;
  // A empties into B or straight out whenever B is free
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill | (a_full_q & ~a_drain);
      b_full_q <= b_fill | (b_full_q & ~b_drain);
    end
  end

  // Ready only from fill state
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  // B is always the older result
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

//--- tag_store_ctrl.sv
`timescale 1ns/1ps
`include "tag_store_consts.svh"

module tag_store_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  tag_req_pkg::store_req_t req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output logic                    evict_req_o,
  input  logic                    evict_valid_i,
  input  tag_geom_pkg::way_vec_t  evict_way_i,
  input  logic                    evict_flag_i,
  output tag_req_pkg::store_res_t res_o,
  output logic                    res_valid_o,
  input  logic                    res_ready_i,
  tag_ram_if.ctrl                 ram
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } ctrl_state_e;

  ctrl_state_e              state_q, state_d;
  tag_req_pkg::store_req_t  req_q;
  logic                     load_req, accept, data_ready;
  tag_geom_pkg::way_vec_t   rvalid_q, hit;
  tag_geom_pkg::tag_entry_t hit_entry, victim_entry, flush_entry;

  // Selects the entry of the one-hot way, zero when none
  function automatic tag_geom_pkg::tag_entry_t pick_entry(
    input tag_geom_pkg::way_vec_t                   sel,
    input tag_geom_pkg::tag_entry_t [`TAG_WAYS-1:0] rd
  );
    tag_geom_pkg::tag_entry_t e;
    e = '0;
    for (int w = 0; w < `TAG_WAYS; w++) begin
      if (sel[w]) begin
        e = e | rd[w];
      end
    end
    return e;
  endfunction

  // Hit only in requested ways with a valid matching tag
  always_comb begin
    for (int w = 0; w < `TAG_WAYS; w++) begin
      hit[w] = req_q.way[w] & ram.ram_rdata[w].valid & (ram.ram_rdata[w].tag == req_q.tag);
    end
  end

  assign hit_entry    = pick_entry(hit, ram.ram_rdata);
  assign victim_entry = pick_entry(evict_way_i, ram.ram_rdata);
  assign flush_entry  = pick_entry(req_q.way, ram.ram_rdata);

  // Read data is usable from the token until the result leaves
  assign data_ready = (|ram.ram_rvalid) | (|rvalid_q);
  assign accept     = res_valid_o & res_ready_i;

  always_comb begin : proc_seq
    state_d       = state_q;
    req_ready_o   = 1'b0;
    load_req      = 1'b0;
    res_valid_o   = 1'b0;
    evict_req_o   = 1'b0;
    ram.ram_req   = '0;
    ram.ram_we    = '0;
    ram.ram_index = req_q.index;
    ram.ram_wdata = '0;
    if (state_q == ST_IDLE) begin
      req_ready_o = 1'b1;
      // Start the read on the accept edge
      if (req_valid_i) begin
        load_req      = 1'b1;
        state_d       = ST_BUSY;
        ram.ram_req   = req_i.way;
        ram.ram_index = req_i.index;
      end
    end else if (req_q.mode == tag_req_pkg::LOOKUP) begin
      if (data_ready) begin
        if (|hit) begin
          res_valid_o = 1'b1;
        end else begin
          // Miss, wait for a victim
          evict_req_o = 1'b1;
          res_valid_o = evict_valid_i;
        end
      end
      if (accept) begin
        if (|hit) begin
          if (req_q.dirty && !hit_entry.dirty) begin
            // Dirty upgrade of the hit entry
            ram.ram_req   = hit;
            ram.ram_we    = hit;
            ram.ram_wdata = tag_geom_pkg::tag_entry_t'{valid: 1'b1, dirty: 1'b1, tag: req_q.tag};
            state_d       = ST_IDLE;
          end else if (req_valid_i && req_i.mode == tag_req_pkg::LOOKUP) begin
            // Clean hit, chain the next lookup
            req_ready_o   = 1'b1;
            load_req      = 1'b1;
            ram.ram_req   = req_i.way;
            ram.ram_index = req_i.index;
          end else begin
            state_d = ST_IDLE;
          end
        end else begin
          // Miss, new tag goes into the victim
          ram.ram_req   = evict_way_i;
          ram.ram_we    = evict_way_i;
          ram.ram_wdata = tag_geom_pkg::tag_entry_t'{
            valid: 1'b1, dirty: req_q.dirty, tag: req_q.tag};
          state_d       = ST_IDLE;
        end
      end
    end else begin
      // Flush reports once the entry is read, then clears it
      res_valid_o = data_ready;
      if (accept) begin
        ram.ram_req = req_q.way;
        ram.ram_we  = req_q.way;
        state_d     = ST_IDLE;
      end
    end
  end

  // Response content
  always_comb begin : proc_res
    res_o = '0;
    if (state_q == ST_BUSY) begin
      if (req_q.mode == tag_req_pkg::LOOKUP) begin
        if (|hit) begin
          res_o.way = hit;
          res_o.hit = 1'b1;
        end else begin
          res_o.way       = evict_way_i;
          res_o.evict     = evict_flag_i;
          res_o.evict_tag = evict_flag_i ? victim_entry.tag : '0;
        end
      end else begin
        res_o.way       = req_q.way;
        res_o.evict     = flush_entry.valid & flush_entry.dirty;
        res_o.evict_tag = res_o.evict ? flush_entry.tag : '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= ST_IDLE;
      req_q    <= '0;
      rvalid_q <= '0;
    end else begin
      state_q <= state_d;
      if (load_req) begin
        req_q <= req_i;
      end
      // Keep the token while the result waits for the spill register
      if (accept) begin
        rvalid_q <= '0;
      end else if (|ram.ram_rvalid) begin
        rvalid_q <= ram.ram_rvalid;
      end
    end
  end

endmodule

//--- tag_store_top.sv
`timescale 1ns/1ps
`include "tag_store_consts.svh"

module tag_store_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  tag_geom_pkg::way_vec_t   spm_lock_i,
  input  tag_req_pkg::store_mode_e req_mode_i,
  input  tag_geom_pkg::way_vec_t   req_way_i,
  input  tag_geom_pkg::index_t     req_index_i,
  input  tag_geom_pkg::tag_t       req_tag_i,
  input  logic                     req_dirty_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  output tag_geom_pkg::way_vec_t   res_way_o,
  output logic                     res_hit_o,
  output logic                     res_evict_o,
  output tag_geom_pkg::tag_t       res_evict_tag_o,
  output logic                     res_valid_o,
  input  logic                     res_ready_i
);

  tag_req_pkg::store_req_t req;
  tag_req_pkg::store_res_t res, res_out;
  logic                    res_valid, res_ready;
  logic                    evict_req, evict_valid, evict_flag;
  tag_geom_pkg::way_vec_t  evict_way, tag_val, tag_dirty;

  tag_ram_if ram_if ();

  // Request fields into the struct
  assign req = '{mode: req_mode_i, way: req_way_i, index: req_index_i,
                 tag: req_tag_i, dirty: req_dirty_i};

  // Held read data feeds the victim choice
  for (genvar w = 0; w < `TAG_WAYS; w++) begin : gen_flags
    assign tag_val[w]   = ram_if.ram_rdata[w].valid;
    assign tag_dirty[w] = ram_if.ram_rdata[w].dirty;
  end

  tag_store_ctrl u_ctrl (
    .clk_i, .rst_i, .req_i(req), .req_valid_i, .req_ready_o,
    .evict_req_o(evict_req), .evict_valid_i(evict_valid), .evict_way_i(evict_way),
    .evict_flag_i(evict_flag), .res_o(res), .res_valid_o(res_valid),
    .res_ready_i(res_ready), .ram(ram_if.ctrl)
  );

  tag_ram_bank u_bank (.clk_i, .rst_i, .ram(ram_if.bank));

  evict_box u_evict (
    .clk_i, .rst_i, .req_i(evict_req), .tag_valid_i(tag_val), .tag_dirty_i(tag_dirty),
    .spm_lock_i, .way_o(evict_way), .evict_o(evict_flag), .valid_o(evict_valid)
  );

  spill_reg u_spill (
    .clk_i, .rst_i, .valid_i(res_valid), .data_i(res), .ready_o(res_ready),
    .valid_o(res_valid_o), .data_o(res_out), .ready_i(res_ready_i)
  );

  // Response struct out to the ports
  assign res_way_o       = res_out.way;
  assign res_hit_o       = res_out.hit;
  assign res_evict_o     = res_out.evict;
  assign res_evict_tag_o = res_out.evict_tag;

endmodule

//--- tag_store_checker.sv
`timescale 1ns/1ps

module tag_store_checker (
  input logic                    clk_i,
  input logic                    rst_i,
  input tag_geom_pkg::way_vec_t  hit_i,
  input tag_geom_pkg::way_vec_t  spm_lock_i,
  input tag_req_pkg::store_res_t res_i,
  input logic                    res_valid_i,
  input logic                    res_ready_i,
  input logic                    evict_req_i
);

  // At most one way may match the request tag
  hit_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(hit_i))
    else $error("more than one way hit");

  // Response names a single way or none
  way_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(res_i.way))
    else $error("response way is not one-hot");

  // Stalled result keeps valid and payload
  res_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
    else $error("result changed while stalled");

  // No victim search with every way locked
  lock_guard: assert property (@(posedge clk_i) disable iff (rst_i)
    evict_req_i |-> !(&spm_lock_i))
    else $error("victim requested with all ways locked");

endmodule

bind tag_store_top tag_store_checker u_checker (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .hit_i       (u_ctrl.hit),
  .spm_lock_i  (spm_lock_i),
  .res_i       (u_ctrl.res_o),
  .res_valid_i (u_ctrl.res_valid_o),
  .res_ready_i (u_ctrl.res_ready_i),
  .evict_req_i (u_ctrl.evict_req_o)
);

//--- tb_tag_store.sv
`timescale 1ns/1ps
`include "tag_store_consts.svh"

module tb_tag_store;

  localparam int SEED    = 32'h6923_b2cd;
  // Upper bound on requests issued by all phases
  localparam int MAX_REQ = 260;
  localparam longint WATCHDOG_NS = (longint'(MAX_REQ) * 200 + 20) * 10;

  logic                     clk_i, rst_i;
  tag_geom_pkg::way_vec_t   spm_lock_i, req_way_i, res_way_o;
  tag_req_pkg::store_mode_e req_mode_i;
  tag_geom_pkg::index_t     req_index_i;
  tag_geom_pkg::tag_t       req_tag_i, res_evict_tag_o;
  logic                     req_dirty_i, req_valid_i, req_ready_o;
  logic                     res_hit_o, res_evict_o, res_valid_o, res_ready_i;

  integer stim_seed, stall_seed;

  // Mirror of the tag memories and the victim pointer
  bit [3:0]                 mir_valid [64];
  bit [3:0]                 mir_dirty [64];
  tag_geom_pkg::tag_t       mir_tag [64][4];
  int                       rr_ptr;
  tag_geom_pkg::way_vec_t   cur_lock;

  // Expected results in issue order with known low for unchecked entries
  tag_req_pkg::store_res_t  exp_q[$];
  bit                       known_q[$];

  tag_store_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Expected response from the store rules applied to the mirror
  function automatic tag_req_pkg::store_res_t ref_result(
    input tag_req_pkg::store_mode_e mode,
    input tag_geom_pkg::way_vec_t   way,
    input tag_geom_pkg::index_t     idx,
    input tag_geom_pkg::tag_t       tag,
    input logic                     dirty
  );
    tag_req_pkg::store_res_t r;
    tag_geom_pkg::way_vec_t  hitw, free;
    int                      vic, c;
    r    = '0;
    hitw = '0;
    vic  = -1;
    if (mode == tag_req_pkg::LOOKUP) begin
      for (int w = 0; w < 4; w++) begin
        if (way[w] && mir_valid[idx][w] && mir_tag[idx][w] == tag) hitw[w] = 1'b1;
      end
      if (hitw != '0) begin
        r.way = hitw;
        r.hit = 1'b1;
        for (int w = 0; w < 4; w++) begin
          if (hitw[w] && dirty) mir_dirty[idx][w] = 1'b1;
        end
      end else begin
        free = ~cur_lock & ~mir_valid[idx];
        for (int w = 3; w >= 0; w--) begin
          if (free[w]) vic = w;
        end
        if (vic < 0) begin
          // Full set picks the first unlocked way from the pointer on
          for (int i = 3; i >= 0; i--) begin
            c = (rr_ptr + i) % 4;
            if (!cur_lock[c]) vic = c;
          end
          rr_ptr = (vic + 1) % 4;
        end
        r.way       = tag_geom_pkg::way_vec_t'(1) << vic;
        r.evict     = mir_valid[idx][vic] & mir_dirty[idx][vic];
        r.evict_tag = r.evict ? mir_tag[idx][vic] : '0;
        mir_valid[idx][vic] = 1'b1;
        mir_dirty[idx][vic] = dirty;
        mir_tag[idx][vic]   = tag;
      end
    end else begin
      for (int w = 0; w < 4; w++) begin
        if (way[w]) vic = w;
      end
      r.way       = way;
      r.evict     = mir_valid[idx][vic] & mir_dirty[idx][vic];
      r.evict_tag = r.evict ? mir_tag[idx][vic] : '0;
      mir_valid[idx][vic] = 1'b0;
      mir_dirty[idx][vic] = 1'b0;
      mir_tag[idx][vic]   = '0;
    end
    return r;
  endfunction

  task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Issue one request and return just after its accept edge
  task automatic send_req(
    input tag_req_pkg::store_mode_e mode,
    input tag_geom_pkg::way_vec_t   way,
    input tag_geom_pkg::index_t     idx,
    input tag_geom_pkg::tag_t       tag,
    input logic                     dirty,
    input bit                       known
  );
    logic ok;
    exp_q.push_back(ref_result(mode, way, idx, tag, dirty));
    known_q.push_back(known);
    req_mode_i  <= mode;
    req_way_i   <= way;
    req_index_i <= idx;
    req_tag_i   <= tag;
    req_dirty_i <= dirty;
    req_valid_i <= 1'b1;
    do begin
      @(negedge clk_i);
      ok = req_ready_o;
      @(posedge clk_i);
    end while (!ok);
  endtask

  task automatic lookup(input int idx, input int tag, input logic dirty);
    send_req(tag_req_pkg::LOOKUP, 4'hf, idx[5:0], tag[9:0], dirty, 1'b1);
  endtask

  task automatic flush(input int idx, input int w, input bit known);
    send_req(tag_req_pkg::FLUSH, 4'b0001 << w, idx[5:0], '0, 1'b0, known);
  endtask

  // Wait until every issued result has left
  task automatic drain();
    req_valid_i <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  task automatic set_lock(input tag_geom_pkg::way_vec_t lock);
    spm_lock_i <= lock;
    cur_lock   = lock;
    @(posedge clk_i);
  endtask

  // Random consumer stalls
  always @(posedge clk_i) begin
    integer r;
    r = $random(stall_seed);
    res_ready_i <= rst_i ? 1'b0 : (r[1:0] != 2'b00);
  end

  // Compare process samples at the falling edge where outputs are settled
  initial begin
    tag_req_pkg::store_res_t held, exp;
    bit                      pend, known;
    pend = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_i) continue;
      if (res_valid_o) begin
        if (pend) begin
          check_eq("res_way_o stall", res_way_o, held.way);
          check_eq("res_hit_o stall", res_hit_o, held.hit);
          check_eq("res_evict_o stall", res_evict_o, held.evict);
          check_eq("res_evict_tag_o stall", res_evict_tag_o, held.evict_tag);
        end
        if (res_ready_i) begin
          pend = 1'b0;
          if (exp_q.size() == 0) begin
            $display("error at %0t ns: result arrived with no request pending", $time);
            $display("FAIL: see errors above");
            $fatal(1, "unexpected result");
          end
          exp   = exp_q.pop_front();
          known = known_q.pop_front();
          if (known) begin
            check_eq("res_way_o", res_way_o, exp.way);
            check_eq("res_hit_o", res_hit_o, exp.hit);
            check_eq("res_evict_o", res_evict_o, exp.evict);
            check_eq("res_evict_tag_o", res_evict_tag_o, exp.evict_tag);
          end
        end else begin
          pend = 1'b1;
          held = '{way: res_way_o, hit: res_hit_o, evict: res_evict_o,
                   evict_tag: res_evict_tag_o};
        end
      end else if (pend) begin
        $display("error at %0t ns: res_valid_o dropped before the transfer", $time);
        $display("FAIL: see errors above");
        $fatal(1, "valid dropped");
      end
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("error: run did not finish within %0d ns", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $fatal(1, "timeout");
  end

  initial begin
    integer r;
    stim_seed   = SEED;
    stall_seed  = ~SEED;
    rr_ptr      = 0;
    cur_lock    = '0;
    rst_i       = 1'b1;
    spm_lock_i  = '0;
    req_mode_i  = tag_req_pkg::LOOKUP;
    req_way_i   = '0;
    req_index_i = '0;
    req_tag_i   = '0;
    req_dirty_i = 1'b0;
    req_valid_i = 1'b0;
    res_ready_i = 1'b0;
    for (int s = 0; s < 64; s++) begin
      mir_valid[s] = '0;
      mir_dirty[s] = '0;
      for (int w = 0; w < 4; w++) mir_tag[s][w] = '0;
    end
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    // Clear the sets in use since their contents are unknown
    for (int s = 0; s < 12; s++) begin
      for (int w = 0; w < 4; w++) flush(s, w, 1'b0);
    end
    drain();

    // Miss on an empty set and then a hit
    lookup(1, 'h011, 1'b0);
    lookup(1, 'h011, 1'b0);
    // Dirty upgrade shows up in the flush
    lookup(1, 'h011, 1'b1);
    flush(1, 0, 1'b1);
    lookup(1, 'h011, 1'b0);
    // Clean flush and then the tag misses again
    flush(1, 0, 1'b1);
    lookup(1, 'h011, 1'b0);
    // Fill a set and keep missing for round robin
    for (int i = 0; i < 10; i++) lookup(2, 'h100 + i, i[0] ^ i[2]);
    drain();

    // Locked ways stay out of victim choice
    set_lock(4'b0011);
    for (int i = 0; i < 7; i++) lookup(3, 'h180 + i, i[0]);
    lookup(3, 'h183, 1'b0);
    drain();
    set_lock(4'b0100);
    for (int i = 0; i < 6; i++) lookup(3, 'h1c0 + i, 1'b1);
    drain();

    // Random mix with back pressure and back-to-back requests
    set_lock(4'b1000);
    for (int n = 0; n < 140; n++) begin
      r = $random(stim_seed);
      if (r[3:0] == 4'd0) begin
        flush(8 + r[13:12], r[21:20], 1'b1);
      end else begin
        lookup(8 + r[13:12], 'h200 + r[10:8], r[16]);
      end
      if (r[25:24] == 2'b00) begin
        req_valid_i <= 1'b0;
        @(posedge clk_i);
      end
    end
    drain();
    repeat (5) @(posedge clk_i);

    if (exp_q.size() == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "run failed");
    end
  end

endmodule

//--- project.f
+incdir+.
tag_geom_pkg.sv
tag_req_pkg.sv
tag_ram_if.sv
tag_ram_bank.sv
evict_box.sv
spill_reg.sv
tag_store_ctrl.sv
tag_store_top.sv
tag_store_checker.sv
tb_tag_store.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench, exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_tag_store -f project.f -o sim_tag_store &&
./obj_dir/sim_tag_store ||
{ echo "simulation failed"; exit 1; }
